// ==== all.f ====
+incdir+.
llm_int_pkg.sv
outlier_scatter.sv
fixed_linear.sv
llm_int.sv
llm_int_assert.sv
llm_int_checker.sv
tb_llm_int.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_llm_int
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_llm_int.sv ====
`timescale 1ns/1ps
`include "llm_int_macros.svh"

module tb_llm_int;

    import llm_int_pkg::*;

    localparam int MAT = `VEC_DIM * `VEC_DIM;
    localparam int NUM_VECTORS = 22;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * (`VEC_DIM + 10) + 200;

    logic clk = 1'b0;
    logic rst_n;
    orig_word_t data_in [`VEC_DIM];
    logic data_in_valid;
    logic data_in_ready;
    orig_word_t weights [2*MAT];
    logic weight_valid;
    logic weight_ready;
    orig_word_t data_out [`VEC_DIM];
    logic data_out_valid;
    logic data_out_ready;

    orig_word_t next_vec [`VEC_DIM];
    logic bp_enable = 1'b0;
    logic bp_stall = 1'b0;
    int stall_left = 0;
    int seed = 75911;
    int test_idx;
    logic test_end;
    logic run_end;
    int error_count;
    int pending_count;

    always #50 clk = ~clk;

    assign data_out_ready = !bp_stall;

    // random stretches of back-pressure, only while enabled
    always @(negedge clk) begin
        if (!bp_enable) begin
            bp_stall = 1'b0;
            stall_left = 0;
        end else if (stall_left > 0) begin
            bp_stall = 1'b1;
            stall_left = stall_left - 1;
        end else if (($random(seed) & 3) == 0) begin
            bp_stall = 1'b1;
            stall_left = {$random(seed)} % 6;
        end else begin
            bp_stall = 1'b0;
        end
    end

    llm_int llm_int_inst (
        .clk(clk),
        .rst_n(rst_n),
        .data_in(data_in),
        .data_in_valid(data_in_valid),
        .data_in_ready(data_in_ready),
        .weights(weights),
        .weight_valid(weight_valid),
        .weight_ready(weight_ready),
        .data_out(data_out),
        .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready)
    );

    llm_int_checker u_checker (
        .clk(clk),
        .rst_n(rst_n),
        .data_in(data_in),
        .data_in_valid(data_in_valid),
        .data_in_ready(data_in_ready),
        .weights(weights),
        .weight_valid(weight_valid),
        .weight_ready(weight_ready),
        .data_out(data_out),
        .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready),
        .test_idx(test_idx),
        .test_end(test_end),
        .run_end(run_end),
        .error_count(error_count),
        .pending_count(pending_count)
    );

    bind llm_int llm_int_assert u_assert (
        .clk(clk),
        .rst_n(rst_n),
        .data_in_ready(data_in_ready),
        .data_out(data_out),
        .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready)
    );

    function automatic orig_word_t small_value();
        return orig_word_t'($random(seed) % 6);  // -5 to 5
    endfunction

    function automatic orig_word_t large_value();
        int mag;
        mag = 6 + int'({$random(seed)} % 3000);
        if ($random(seed) & 1) begin
            mag = -mag;
        end
        return orig_word_t'(mag);
    endfunction

    // bit i of large_mask puts an outlier at index i
    task automatic make_vector(input int large_mask);
        for (int i = 0; i < `VEC_DIM; i++) begin
            next_vec[i] = large_mask[i] ? large_value() : small_value();
        end
    endtask

    task automatic load_random_weights();
        @(negedge clk);
        for (int k = 0; k < 2 * MAT; k++) begin
            weights[k] = orig_word_t'($random(seed));
        end
        weight_valid = 1'b1;
        @(posedge clk);
        while (!weight_ready) @(posedge clk);
        @(negedge clk);
        weight_valid = 1'b0;
    endtask

    task automatic send_vector();
        @(negedge clk);
        data_in = next_vec;
        data_in_valid = 1'b1;
        @(posedge clk);
        while (!data_in_ready) @(posedge clk);
        @(negedge clk);
        data_in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (pending_count != 0) @(negedge clk);
    endtask

    task automatic end_test(input int idx);
        @(negedge clk);
        test_idx = idx;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        data_in_valid = 1'b0;
        weight_valid = 1'b0;
        test_idx = 0;
        test_end = 1'b0;
        run_end = 1'b0;
        for (int i = 0; i < `VEC_DIM; i++) begin
            data_in[i] = '0;
            next_vec[i] = '0;
        end
        for (int k = 0; k < 2 * MAT; k++) begin
            weights[k] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // a vector waits at the input until the first matrix arrives
        make_vector(4'b0010);
        @(negedge clk);
        data_in = next_vec;
        data_in_valid = 1'b1;
        repeat (4) @(negedge clk);
        load_random_weights();
        @(posedge clk);
        while (!data_in_ready) @(posedge clk);
        @(negedge clk);
        data_in_valid = 1'b0;
        wait_idle();
        end_test(1);

        repeat (4) begin
            make_vector(0);
            send_vector();
        end
        wait_idle();
        end_test(2);

        make_vector(4'b0100);
        send_vector();
        make_vector(4'b1001);
        send_vector();
        make_vector(4'b1011);  // index 3 is past the slot limit
        send_vector();
        wait_idle();
        end_test(3);

        repeat (3) begin
            make_vector({$random(seed)} % 16);
            send_vector();
        end
        wait_idle();
        end_test(4);

        bp_enable = 1'b1;
        repeat (8) begin
            make_vector({$random(seed)} % 16);
            send_vector();
        end
        wait_idle();
        bp_enable = 1'b0;
        end_test(5);

        load_random_weights();
        repeat (3) begin
            make_vector({$random(seed)} % 16);
            send_vector();
        end
        wait_idle();
        end_test(6);

        @(negedge clk);
        run_end = 1'b1;
        @(negedge clk);
        run_end = 1'b0;
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== llm_int_checker.sv ====
`timescale 1ns/1ps
`include "llm_int_macros.svh"

module llm_int_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  llm_int_pkg::orig_word_t data_in [`VEC_DIM],
    input  logic                    data_in_valid,
    input  logic                    data_in_ready,
    input  llm_int_pkg::orig_word_t weights [2*`VEC_DIM*`VEC_DIM],
    input  logic                    weight_valid,
    input  logic                    weight_ready,
    input  llm_int_pkg::orig_word_t data_out [`VEC_DIM],
    input  logic                    data_out_valid,
    input  logic                    data_out_ready,
    input  int                      test_idx,
    input  logic                    test_end,
    input  logic                    run_end,
    output int                      error_count,
    output int                      pending_count
);

    import llm_int_pkg::*;

    localparam int W = `ORIG_PREC;
    localparam int MAT = `VEC_DIM * `VEC_DIM;

    typedef logic [`VEC_DIM*W-1:0] vec_bits_t;

    orig_word_t cur_weights [2*MAT];
    vec_bits_t expected_q [$];  // one entry per accepted input, oldest first
    vec_bits_t got;
    vec_bits_t want;
    vec_bits_t prev_out;
    logic loaded = 1'b0;
    logic busy = 1'b0;  // an accepted vector has not been delivered yet
    logic prev_valid = 1'b0;
    logic prev_ready = 1'b1;
    logic after_reset = 1'b0;
    int cyc = 0;
    int accept_cyc = 0;
    int checked = 0;
    int test_checked = 0;
    int test_errors = 0;
    int errors = 0;
    int pending = 0;

    assign error_count = errors;
    assign pending_count = pending;

    // scatter by magnitude and slot limit, quantize by shift, rescale and wrap to 16 bits
    function automatic vec_bits_t reference_output(input orig_word_t vec [`VEC_DIM],
                                                   input orig_word_t mat [2*MAT]);
        vec_bits_t result;
        int high_val [`VEC_DIM];
        int low_val [`VEC_DIM];
        int slots;
        int value;
        int high_dot;
        int low_dot;
        int total;
        slots = 0;
        for (int i = 0; i < `VEC_DIM; i++) begin
            value = int'(vec[i]);
            if ((value >= `OUTLIER_THRESHOLD || value <= -`OUTLIER_THRESHOLD)
                    && slots < `HIGH_SLOTS) begin
                high_val[i] = value;
                low_val[i] = 0;
                slots = slots + 1;
            end else begin
                high_val[i] = 0;
                low_val[i] = value >>> `QSHIFT;
            end
        end
        for (int i = 0; i < `VEC_DIM; i++) begin
            high_dot = 0;
            low_dot = 0;
            for (int j = 0; j < `VEC_DIM; j++) begin
                high_dot = high_dot + int'(mat[i*`VEC_DIM+j]) * high_val[j];
                low_dot = low_dot + (int'(mat[MAT+i*`VEC_DIM+j]) >>> `QSHIFT) * low_val[j];
            end
            total = high_dot + (low_dot <<< (2 * `QSHIFT));  // int wraps, low bits stay exact
            result[i*W +: W] = total[W-1:0];
        end
        return result;
    endfunction

    function automatic string test_name(input int idx);
        case (idx)
            1: return "reset and weight load";
            2: return "all-small inputs";
            3: return "outlier routing";
            4: return "latency";
            5: return "back-pressure";
            6: return "weight reload";
            default: return "unnamed";
        endcase
    endfunction

    task automatic count_error();
        errors = errors + 1;
        test_errors = test_errors + 1;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        count_error();
    endtask

    always @(posedge clk) begin
        for (int i = 0; i < `VEC_DIM; i++) begin
            got[i*W +: W] = data_out[i];
        end
        if (!rst_n) begin
            loaded = 1'b0;
            busy = 1'b0;
            prev_valid = 1'b0;
            after_reset = 1'b1;
            expected_q.delete();
        end else begin
            if (after_reset && data_out_valid) begin
                report_failure("data_out_valid was high right after reset");
            end
            after_reset = 1'b0;
            // the engines take weights only when idle, and data only once a matrix is held
            if (weight_ready !== !busy) begin
                report_failure("weight_ready did not follow the idle state of the engines");
            end
            if (data_in_ready !== (!busy && loaded)) begin
                report_failure("data_in_ready did not follow the idle state and a loaded matrix");
            end
            if (weight_valid && weight_ready) begin
                cur_weights = weights;  // the engines compute with the matrix taken at this edge
                loaded = 1'b1;
            end
            if (data_in_valid && data_in_ready) begin
                expected_q.push_back(reference_output(data_in, cur_weights));
                accept_cyc = cyc;
                busy = 1'b1;
            end
            if (data_in_ready && data_out_valid) begin
                report_failure("an input could be accepted while a result was held");
            end
            // valid is first seen high one edge after the edge that raised it
            if (data_out_valid && !prev_valid && cyc != accept_cyc + `VEC_DIM + 2) begin
                report_failure($sformatf("data_out_valid rose %0d edges after the input, not %0d",
                                         cyc - accept_cyc - 1, `VEC_DIM + 1));
            end
            if (prev_valid && !prev_ready && (!data_out_valid || got != prev_out)) begin
                report_failure("the held result changed or dropped valid under back-pressure");
            end
            if (data_out_valid && data_out_ready) begin
                busy = 1'b0;
                if (expected_q.size() == 0) begin
                    report_failure("a result was delivered with no input pending");
                end else begin
                    want = expected_q.pop_front();
                    checked = checked + 1;
                    test_checked = test_checked + 1;
                    for (int i = 0; i < `VEC_DIM; i++) begin
                        if (got[i*W +: W] !== want[i*W +: W]) begin
                            $display("mismatch at %0t ns: row %0d is %0d, expected %0d", $time, i,
                                     $signed(got[i*W +: W]), $signed(want[i*W +: W]));
                            count_error();
                        end
                    end
                end
            end
            prev_valid = data_out_valid;
            prev_ready = data_out_ready;
            prev_out = got;
        end
        cyc = cyc + 1;
        if (test_end) begin
            $display("test %0d %s: %0d results checked, %0d errors", test_idx,
                     test_name(test_idx), test_checked, test_errors);
            test_checked = 0;
            test_errors = 0;
        end
        if (run_end) begin
            if (expected_q.size() != 0) begin
                report_failure($sformatf("%0d results never arrived", expected_q.size()));
            end
            $display("total: %0d results checked, %0d errors", checked, errors);
        end
        pending = expected_q.size();
    end

endmodule

// ==== llm_int_assert.sv ====
`timescale 1ns/1ps
`include "llm_int_macros.svh"

module llm_int_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    data_in_ready,
    input llm_int_pkg::orig_word_t data_out [`VEC_DIM],
    input logic                    data_out_valid,
    input logic                    data_out_ready
);

    import llm_int_pkg::*;

    logic [`VEC_DIM*`ORIG_PREC-1:0] out_bits;  // output vector flattened for $stable

    always_comb begin
        for (int i = 0; i < `VEC_DIM; i++) begin
            out_bits[i*`ORIG_PREC +: `ORIG_PREC] = data_out[i];
        end
    end

    valid_low_after_reset: assert property (@(posedge clk) !rst_n |=> !data_out_valid)
        else $error("data_out_valid is high in the cycle after reset");

    // a held result keeps its valid and its data until the sink takes it
    output_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(out_bits))
        else $error("data_out changed or lost valid while data_out_ready was low");

    no_input_during_output: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_in_ready && data_out_valid))
        else $error("data_in_ready is high while data_out_valid is high");

endmodule

// ==== llm_int.sv ====
`timescale 1ns/1ps
`include "llm_int_macros.svh"

module llm_int (
    input  logic                    clk,
    input  logic                    rst_n,

    input  llm_int_pkg::orig_word_t data_in [`VEC_DIM],
    input  logic                    data_in_valid,
    output logic                    data_in_ready,

    // full-precision matrix first, then the matrix to be quantized, both row-major
    input  llm_int_pkg::orig_word_t weights [2*`VEC_DIM*`VEC_DIM],
    input  logic                    weight_valid,
    output logic                    weight_ready,

    output llm_int_pkg::orig_word_t data_out [`VEC_DIM],
    output logic                    data_out_valid,
    input  logic                    data_out_ready
);

    import llm_int_pkg::*;

    localparam int MAT_SIZE = `VEC_DIM * `VEC_DIM;
    localparam int LOW_ACC_W = 2 * `RED_PREC + $clog2(`VEC_DIM);
    localparam int HIGH_ACC_W = 2 * `ORIG_PREC + $clog2(`VEC_DIM);

    orig_word_t high_vec [`VEC_DIM];
    orig_word_t low_vec [`VEC_DIM];
    red_word_t low_q [`VEC_DIM];

    orig_word_t weight_high [MAT_SIZE];
    red_word_t weight_low_q [MAT_SIZE];

    logic signed [LOW_ACC_W-1:0] low_acc [`VEC_DIM];
    logic signed [HIGH_ACC_W-1:0] high_acc [`VEC_DIM];
    orig_word_t low_scaled [`VEC_DIM];
    orig_word_t high_part [`VEC_DIM];

    logic low_in_ready, high_in_ready;
    logic low_w_ready, high_w_ready;
    logic low_out_valid, high_out_valid;

    outlier_scatter u_scatter (
        .data_in(data_in),
        .high_vec(high_vec),
        .low_vec(low_vec)
    );

    // arithmetic shift keeps the sign of the quantized activations
    for (genvar i = 0; i < `VEC_DIM; i++) begin : g_quant_in
        assign low_q[i] = red_word_t'(low_vec[i] >>> `QSHIFT);
    end

    for (genvar k = 0; k < MAT_SIZE; k++) begin : g_split_w
        assign weight_high[k] = weights[k];
        assign weight_low_q[k] = red_word_t'(weights[MAT_SIZE + k] >>> `QSHIFT);
    end

    // both engines run in lockstep, so the joined handshake is a plain AND
    assign data_in_ready = low_in_ready & high_in_ready;
    assign weight_ready = low_w_ready & high_w_ready;
    assign data_out_valid = low_out_valid & high_out_valid;

    fixed_linear #(
        .PREC(`RED_PREC)
    ) u_low_linear (
        .clk(clk),
        .rst_n(rst_n),
        .data_in(low_q),
        .data_in_valid(data_in_valid),
        .data_in_ready(low_in_ready),
        .weight(weight_low_q),
        .weight_valid(weight_valid),
        .weight_ready(low_w_ready),
        .data_out(low_acc),
        .data_out_valid(low_out_valid),
        .data_out_ready(data_out_ready)
    );

    fixed_linear #(
        .PREC(`ORIG_PREC)
    ) u_high_linear (
        .clk(clk),
        .rst_n(rst_n),
        .data_in(high_vec),
        .data_in_valid(data_in_valid),
        .data_in_ready(high_in_ready),
        .weight(weight_high),
        .weight_valid(weight_valid),
        .weight_ready(high_w_ready),
        .data_out(high_acc),
        .data_out_valid(high_out_valid),
        .data_out_ready(data_out_ready)
    );

    // rescale the quantized product back by both quantizing shifts, then gather
    for (genvar i = 0; i < `VEC_DIM; i++) begin : g_gather
        assign low_scaled[i] = orig_word_t'(low_acc[i] <<< (2 * `QSHIFT));
        assign high_part[i] = orig_word_t'(high_acc[i]);  // wraps to the output width
        assign data_out[i] = high_part[i] + low_scaled[i];
    end

endmodule

// ==== fixed_linear.sv ====
`timescale 1ns/1ps
`include "llm_int_macros.svh"

module fixed_linear #(
    parameter int PREC = `ORIG_PREC
) (
    input  logic                                             clk,
    input  logic                                             rst_n,

    input  logic signed [PREC-1:0]                           data_in [`VEC_DIM],
    input  logic                                             data_in_valid,
    output logic                                             data_in_ready,

    input  logic signed [PREC-1:0]                           weight [`VEC_DIM*`VEC_DIM],
    input  logic                                             weight_valid,
    output logic                                             weight_ready,

    output logic signed [2*PREC+$clog2(`VEC_DIM)-1:0]        data_out [`VEC_DIM],
    output logic                                             data_out_valid,
    input  logic                                             data_out_ready
);

    import llm_int_pkg::*;

    localparam int ACC_W = 2 * PREC + $clog2(`VEC_DIM);
    localparam int ROW_W = $clog2(`VEC_DIM);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`VEC_DIM - 1);

    linear_state_e state;
    logic [ROW_W-1:0] row_idx;                        // row being computed
    logic loaded;                                      // a matrix has been received since reset

    logic signed [PREC-1:0] weight_q [`VEC_DIM*`VEC_DIM];
    logic signed [PREC-1:0] in_q [`VEC_DIM];
    logic signed [ACC_W-1:0] row_sum;

    logic data_fire;
    logic weight_fire;

    assign weight_ready = (state == LIN_IDLE);
    assign data_in_ready = (state == LIN_IDLE) && loaded;  // no data before the first matrix

    assign weight_fire = weight_valid && weight_ready;
    assign data_fire = data_in_valid && data_in_ready;

    // dot product of the current row with the held input vector
    always_comb begin
        row_sum = '0;
        for (int j = 0; j < `VEC_DIM; j++) begin
            row_sum = row_sum + weight_q[row_idx * `VEC_DIM + j] * in_q[j];
        end
    end

    // control path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LIN_IDLE;
            row_idx <= '0;
            loaded <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            case (state)
                LIN_IDLE: begin
                    if (weight_fire) begin
                        loaded <= 1'b1;
                    end
                    if (data_fire) begin
                        state <= LIN_COMPUTE;
                        row_idx <= '0;
                    end
                end
                LIN_COMPUTE: begin
                    row_idx <= row_idx + 1'b1;  // wraps back to row 0 after the last row
                    if (row_idx == LAST_ROW) begin
                        state <= LIN_HOLD;
                    end
                end
                LIN_HOLD: begin
                    // first hold cycle lets the last row settle before valid is raised
                    if (!data_out_valid) begin
                        data_out_valid <= 1'b1;
                    end else if (data_out_ready) begin
                        data_out_valid <= 1'b0;
                        state <= LIN_IDLE;
                    end
                end
                default: begin
                    state <= LIN_IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (weight_fire) begin
            weight_q <= weight;  // held until the next weight transfer
        end
        if (data_fire) begin
            in_q <= data_in;
        end
        if (state == LIN_COMPUTE) begin
            data_out[row_idx] <= row_sum;  // one output row per cycle
        end
    end

endmodule

// ==== outlier_scatter.sv ====
`timescale 1ns/1ps
`include "llm_int_macros.svh"

module outlier_scatter (
    input  llm_int_pkg::orig_word_t data_in [`VEC_DIM],
    output llm_int_pkg::orig_word_t high_vec [`VEC_DIM],
    output llm_int_pkg::orig_word_t low_vec [`VEC_DIM]
);

    import llm_int_pkg::*;

    // scan from index 0 upward, the first outliers claim the high slots
    always_comb begin
        int taken;
        orig_word_t elem;
        logic is_outlier;

        taken = 0;
        for (int i = 0; i < `VEC_DIM; i++) begin
            elem = data_in[i];
            // compared on both sides so the most negative word needs no abs
            is_outlier = (elem >= `OUTLIER_THRESHOLD) || (elem <= -`OUTLIER_THRESHOLD);
            high_vec[i] = '0;
            low_vec[i] = '0;
            if (is_outlier && (taken < `HIGH_SLOTS)) begin
                high_vec[i] = elem;
                taken = taken + 1;
            end else begin
                low_vec[i] = elem;  // small values and outliers past the slot limit
            end
        end
    end

endmodule

// ==== llm_int_pkg.sv ====
`include "llm_int_macros.svh"

package llm_int_pkg;

    typedef logic signed [`ORIG_PREC-1:0] orig_word_t;  // activations, weights and outputs
    typedef logic signed [`RED_PREC-1:0] red_word_t;    // quantized word

    // engine states of fixed_linear
    typedef enum logic [1:0] {
        LIN_IDLE,
        LIN_COMPUTE,
        LIN_HOLD
    } linear_state_e;

endpackage

// ==== llm_int_macros.svh ====
`ifndef LLM_INT_MACROS_SVH
`define LLM_INT_MACROS_SVH

// precisions of the two datapaths
`define ORIG_PREC 16
`define RED_PREC 8

// quantizing shift, the rescale shift is twice this
`define QSHIFT (`ORIG_PREC - `RED_PREC)

// vector length and side of the square weight matrix
`define VEC_DIM 4

// outlier routing
`define HIGH_SLOTS 2
`define OUTLIER_THRESHOLD 6

`endif
